/* Bender.yml */
package:
  name: riscv_decode

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/decode_pkg.sv
      - source/instr_classifier.sv
      - source/operand_port.sv
      - source/decode_sequencer.sv
      - source/riscv_decode.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/riscv_decode_props.sv
      - tests/riscv_decode_tb.sv

/* all.f */
+incdir+source
source/isa_pkg.sv
source/decode_pkg.sv
source/instr_classifier.sv
source/operand_port.sv
source/decode_sequencer.sv
source/riscv_decode.sv
tests/riscv_decode_props.sv
tests/riscv_decode_tb.sv

/* source/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath and register file widths.
`define XLEN 32
`define REG_AW 8

// Major opcodes, instruction bits 6 to 2.
`define OPC_LOAD    5'b00000
`define OPC_MISCMEM 5'b00011
`define OPC_IMM     5'b00100
`define OPC_AUIPC   5'b00101
`define OPC_STORE   5'b01000
`define OPC_OP      5'b01100
`define OPC_LUI     5'b01101
`define OPC_BRANCH  5'b11000
`define OPC_JALR    5'b11001
`define OPC_JAL     5'b11011
`define OPC_SYSTEM  5'b11100

// Trap causes.
`define CAUSE_ILLEGAL 4'h2
`define CAUSE_BREAK   4'h3
`define CAUSE_ECALL   4'hB

`endif

/* source/decode_pkg.sv */
`include "decode_defines.svh"

package decode_pkg;

	typedef enum logic [1:0]
	{
		sel_imm = 2'b00,
		sel_reg = 2'b01
	} operand_sel_e;

	// Command flags seen by execute.
	typedef struct packed
	{
		logic loadop3;
		logic signed_op; // Signed load, arithmetic shift, signed mul/div.
		logic signed_b;
		logic dbus;
		logic dbus_store;
		logic dbus_byte;
		logic dbus_hword;
		logic addsub;
		logic negate_op2;
		logic mul;
		logic mul_high;
		logic div;
		logic div_mod;
		logic cmp;
		logic slt;
		logic jump;
		logic and_op;
		logic xor_op;
		logic shift;
		logic shift_right;
		logic trap;
	} dec_cmd_t;

	typedef struct packed
	{
		dec_cmd_t cmd;
		logic [3:0] jump_type;
		logic [`REG_AW-1:0] dst;
		logic [11:0] displacement;
		logic [3:0] trap_cause;
		logic [29:0] epc;
		operand_sel_e op1_sel;
		operand_sel_e op2_sel;
		logic [`XLEN-1:0] op1_imm;
		logic [`XLEN-1:0] op2_imm;
		logic [`XLEN-1:0] op3;
	} dec_item_t;

endpackage

/* source/decode_sequencer.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_sequencer
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic valid_i,
	output logic ready_o,
	input  logic jump_valid_i,
	input  logic ready_i,
	input  decode_pkg::dec_item_t next_item_i,
	input  logic branch_i,
	input  logic [`XLEN-1:0] branch_target_i,
	output logic busy_o,
	output logic valid_o,
	output decode_pkg::dec_item_t item_o
);
	import decode_pkg::*;

	typedef enum logic
	{
		st_regular,
		st_branch_jump
	} state_e;

	state_e state_q;
	dec_item_t item_q;
	logic valid_q;
	logic stall;
	logic [`XLEN-1:0] target_q;

	assign stall = valid_q & ~ready_i; // Execute has not taken the item.
	assign busy_o = stall | (state_q == st_branch_jump);
	assign ready_o = ~busy_o;
	assign valid_o = valid_q;
	assign item_o = item_q;

	always_ff @(posedge clk_i)
	begin
		if (ready_o && valid_i && branch_i)
			target_q <= branch_target_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state_q <= st_regular;
			valid_q <= 1'b0;
			item_q <= '0;
		end
		else if (jump_valid_i)
		begin
			// Taken jump in execute wins over a stall.
			state_q <= st_regular;
			valid_q <= 1'b0;
		end
		else if (!stall)
		begin
			if (state_q == st_branch_jump)
			begin
				// Second half of a branch, jump_type and epc carry over.
				item_q.cmd <= '{jump: 1'b1, default: 1'b0};
				item_q.op1_sel <= sel_imm;
				item_q.op1_imm <= target_q;
				valid_q <= 1'b1;
				state_q <= st_regular;
			end
			else if (valid_i)
			begin
				item_q <= next_item_i;
				valid_q <= 1'b1;
				if (branch_i)
					state_q <= st_branch_jump;
			end
			else
			begin
				item_q <= '0;
				valid_q <= 1'b0;
			end
		end
	end

endmodule

/* source/instr_classifier.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module instr_classifier
(
	input  logic [`XLEN-1:0] word_i,
	input  logic [29:0] next_ip_i,
	output decode_pkg::dec_item_t item_o,
	output logic branch_o,
	output logic [`XLEN-1:0] branch_target_o
);
	import isa_pkg::*;
	import decode_pkg::*;

	instr_fields_t f;
	opclass_e cls;
	logic [29:0] cur_ip;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] imm_itype;
	logic [`XLEN-1:0] imm_utype;
	logic [`XLEN-1:0] imm_jtype;
	logic [`XLEN-1:0] imm_btype;
	logic [`REG_AW-1:0] rd_ext;
	logic illegal;
	dec_item_t item;

	function automatic opclass_e classify(input logic [4:0] opc);
		case (opc)
			`OPC_IMM:     classify = cls_imm;
			`OPC_OP:      classify = cls_op;
			`OPC_JAL:     classify = cls_jal;
			`OPC_JALR:    classify = cls_jalr;
			`OPC_LOAD:    classify = cls_load;
			`OPC_STORE:   classify = cls_store;
			`OPC_BRANCH:  classify = cls_branch;
			`OPC_LUI:     classify = cls_lui;
			`OPC_AUIPC:   classify = cls_auipc;
			`OPC_SYSTEM:  classify = cls_system;
			`OPC_MISCMEM: classify = cls_miscmem;
			default:      classify = cls_invalid;
		endcase
	endfunction

	assign f = word_i[31:2];
	assign cls = classify(f.opcode);
	assign cur_ip = next_ip_i - 30'd1;
	assign pc = {cur_ip, 2'b00};
	assign rd_ext = {{(`REG_AW-5){1'b0}}, f.rd};

	assign imm_itype = {{20{word_i[31]}}, word_i[31:20]};
	assign imm_utype = {word_i[31:12], 12'h000};
	assign imm_jtype = {{11{word_i[31]}}, word_i[31], word_i[19:12], word_i[20], word_i[30:21], 1'b0};
	assign imm_btype = {{19{word_i[31]}}, word_i[31], word_i[7], word_i[30:25], word_i[11:8], 1'b0};
	assign branch_target_o = pc + imm_btype;

	always_comb
	begin
		item = '0;
		item.epc = cur_ip;
		branch_o = 1'b0;
		illegal = (word_i[1:0] != 2'b11); // Compressed words are not supported.
		case (cls)
			cls_imm, cls_op:
			begin
				item.op1_sel = sel_reg;
				item.dst = rd_ext;
				if (cls == cls_op)
					item.op2_sel = sel_reg;
				else
					item.op2_imm = imm_itype;
				if (cls == cls_op && f.funct7 == 7'b0000001)
				begin
					if (!f.funct3[2])
					begin
						item.cmd.mul = 1'b1;
						item.cmd.mul_high = |f.funct3[1:0];
						item.cmd.signed_op = ^f.funct3[1:0]; // MULH and MULHSU.
						item.cmd.signed_b = (f.funct3[1:0] == 2'b01);
					end
					else
					begin
						item.cmd.div = 1'b1;
						item.cmd.div_mod = f.funct3[1];
						item.cmd.signed_op = ~f.funct3[0];
					end
				end
				else
				begin
					case (f.funct3)
						3'b000:
						begin
							item.cmd.addsub = 1'b1;
							item.cmd.negate_op2 = (cls == cls_op) & word_i[30]; // SUB.
						end
						3'b001: item.cmd.shift = 1'b1;
						3'b101:
						begin
							item.cmd.shift = 1'b1;
							item.cmd.shift_right = 1'b1;
							item.cmd.signed_op = word_i[30];
						end
						3'b010, 3'b011:
						begin
							item.cmd.cmp = 1'b1;
							item.cmd.negate_op2 = 1'b1;
							item.cmd.slt = 1'b1;
							item.jump_type = {2'b01, f.funct3[0], 1'b0};
						end
						3'b100: item.cmd.xor_op = 1'b1;
						3'b110:
						begin
							// OR is encoded as both logic flags.
							item.cmd.and_op = 1'b1;
							item.cmd.xor_op = 1'b1;
						end
						default: item.cmd.and_op = 1'b1;
					endcase
				end
			end
			cls_jal, cls_jalr:
			begin
				item.cmd.jump = 1'b1;
				item.cmd.loadop3 = 1'b1;
				item.op3 = {next_ip_i, 2'b00}; // Link address.
				item.dst = rd_ext;
				if (cls == cls_jal)
					item.op1_imm = pc + imm_jtype;
				else
				begin
					item.op1_sel = sel_reg;
					item.displacement = word_i[31:20];
				end
			end
			cls_branch:
			begin
				item.op1_sel = sel_reg;
				item.op2_sel = sel_reg;
				item.jump_type = {1'b0, f.funct3};
				item.cmd.cmp = 1'b1;
				item.cmd.negate_op2 = 1'b1;
				branch_o = ~illegal;
			end
			cls_load, cls_store:
			begin
				item.op1_sel = sel_reg;
				item.cmd.dbus = 1'b1;
				item.cmd.dbus_byte = (f.funct3[1:0] == 2'b00);
				item.cmd.dbus_hword = (f.funct3[1:0] == 2'b01);
				if (cls == cls_load)
				begin
					item.displacement = word_i[31:20];
					item.dst = rd_ext;
					item.cmd.signed_op = ~f.funct3[2];
				end
				else
				begin
					item.op2_sel = sel_reg;
					item.displacement = {word_i[31:25], word_i[11:7]};
					item.cmd.dbus_store = 1'b1;
				end
			end
			cls_lui, cls_auipc:
			begin
				item.cmd.addsub = 1'b1;
				item.op1_imm = (cls == cls_lui) ? '0 : pc;
				item.op2_imm = imm_utype;
				item.dst = rd_ext;
			end
			cls_system:
			begin
				item.cmd.trap = 1'b1;
				item.cmd.jump = 1'b1;
				if (f.funct3 != 3'b000 || word_i[21])
					illegal = 1'b1; // CSR access and xRET.
				else
					item.trap_cause = word_i[20] ? `CAUSE_BREAK : `CAUSE_ECALL;
			end
			cls_miscmem: illegal = illegal | (f.funct3 != 3'b000); // FENCE only.
			default: illegal = 1'b1;
		endcase

		if (illegal)
		begin
			item = '0;
			item.epc = cur_ip;
			item.cmd.trap = 1'b1;
			item.cmd.jump = 1'b1;
			item.trap_cause = `CAUSE_ILLEGAL;
		end
		item_o = item;
	end

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

	// Instruction class after opcode decode.
	typedef enum logic [3:0]
	{
		cls_imm     = 4'd0,
		cls_op      = 4'd1,
		cls_jal     = 4'd2,
		cls_jalr    = 4'd3,
		cls_load    = 4'd4,
		cls_store   = 4'd5,
		cls_branch  = 4'd6,
		cls_lui     = 4'd7,
		cls_auipc   = 4'd8,
		cls_system  = 4'd9,
		cls_miscmem = 4'd10,
		cls_invalid = 4'd11
	} opclass_e;

	// Word bits 31 to 2, MSB first.
	typedef struct packed
	{
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [4:0] opcode;
	} instr_fields_t;

endpackage

/* source/operand_port.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module operand_port
(
	input  logic clk_i,
	input  logic busy_i,
	input  logic [4:0] rs_i,
	input  decode_pkg::operand_sel_e sel_i,
	input  logic [`XLEN-1:0] imm_i,
	output logic [`REG_AW-1:0] raddr_o,
	input  logic [`XLEN-1:0] rdata_i,
	output logic [`XLEN-1:0] operand_o
);
	import decode_pkg::*;

	logic [4:0] rs_q;
	logic zero_q; // Captured index is x0.

	// Index of the instruction now in the output stage.
	always_ff @(posedge clk_i)
	begin
		if (!busy_i)
		begin
			rs_q <= rs_i;
			zero_q <= (rs_i == 5'd0);
		end
	end

	// Hold the address so the read data stays put under a stall.
	assign raddr_o = {{(`REG_AW-5){1'b0}}, (busy_i ? rs_q : rs_i)};

	always_comb
	begin
		if (sel_i == sel_imm)
			operand_o = imm_i;
		else if (zero_q)
			operand_o = '0;
		else
			operand_o = rdata_i;
	end

endmodule

/* source/riscv_decode.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module riscv_decode
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic [`XLEN-1:0] word_i,
	input  logic [29:0] next_ip_i,
	input  logic valid_i,
	output logic ready_o,
	input  logic jump_valid_i,
	input  logic ready_i,
	output logic valid_o,
	output decode_pkg::dec_cmd_t cmd_o,
	output logic [3:0] jump_type_o,
	output logic [`REG_AW-1:0] dst_o,
	output logic [11:0] displacement_o,
	output logic [3:0] trap_cause_o,
	output logic [29:0] epc_o,
	output logic [`XLEN-1:0] op1_o,
	output logic [`XLEN-1:0] op2_o,
	output logic [`XLEN-1:0] op3_o,
	output logic [`REG_AW-1:0] sp_raddr1_o,
	input  logic [`XLEN-1:0] sp_rdata1_i,
	output logic [`REG_AW-1:0] sp_raddr2_o,
	input  logic [`XLEN-1:0] sp_rdata2_i
);
	import isa_pkg::*;
	import decode_pkg::*;

	instr_fields_t fields;
	dec_item_t next_item;
	dec_item_t item_q;
	logic branch;
	logic [`XLEN-1:0] branch_target;
	logic busy;

	assign fields = word_i[31:2];

	instr_classifier i_classifier
	(
		.word_i          (word_i),
		.next_ip_i       (next_ip_i),
		.item_o          (next_item),
		.branch_o        (branch),
		.branch_target_o (branch_target)
	);

	decode_sequencer i_sequencer
	(
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.valid_i         (valid_i),
		.ready_o         (ready_o),
		.jump_valid_i    (jump_valid_i),
		.ready_i         (ready_i),
		.next_item_i     (next_item),
		.branch_i        (branch),
		.branch_target_i (branch_target),
		.busy_o          (busy),
		.valid_o         (valid_o),
		.item_o          (item_q)
	);

	operand_port i_op1_port
	(
		.clk_i     (clk_i),
		.busy_i    (busy),
		.rs_i      (fields.rs1),
		.sel_i     (item_q.op1_sel),
		.imm_i     (item_q.op1_imm),
		.raddr_o   (sp_raddr1_o),
		.rdata_i   (sp_rdata1_i),
		.operand_o (op1_o)
	);

	operand_port i_op2_port
	(
		.clk_i     (clk_i),
		.busy_i    (busy),
		.rs_i      (fields.rs2),
		.sel_i     (item_q.op2_sel),
		.imm_i     (item_q.op2_imm),
		.raddr_o   (sp_raddr2_o),
		.rdata_i   (sp_rdata2_i),
		.operand_o (op2_o)
	);

	assign cmd_o = item_q.cmd;
	assign jump_type_o = item_q.jump_type;
	assign dst_o = item_q.dst;
	assign displacement_o = item_q.displacement;
	assign trap_cause_o = item_q.trap_cause;
	assign epc_o = item_q.epc;
	assign op3_o = item_q.op3;

endmodule

/* tests/riscv_decode_props.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module riscv_decode_props
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic ready_i,
	input  logic jump_valid_i,
	input  logic valid_o,
	input  logic ready_o,
	input  decode_pkg::dec_cmd_t cmd_o,
	input  logic [3:0] jump_type_o,
	input  logic [`REG_AW-1:0] dst_o,
	input  logic [11:0] displacement_o,
	input  logic [3:0] trap_cause_o,
	input  logic [29:0] epc_o,
	input  logic [`XLEN-1:0] op1_o,
	input  logic [`XLEN-1:0] op2_o,
	input  logic [`XLEN-1:0] op3_o
);
	int fails = 0;
	logic compare_item;

	assign compare_item = valid_o & cmd_o.cmp & ~cmd_o.slt; // First half of a branch.

	hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		valid_o && !ready_i && !jump_valid_i |=> valid_o && $stable(cmd_o)
			&& $stable(jump_type_o) && $stable(dst_o) && $stable(displacement_o)
			&& $stable(trap_cause_o) && $stable(epc_o) && $stable(op1_o)
			&& $stable(op2_o) && $stable(op3_o))
	else
	begin
		fails++;
		$error("Decoder output changed while execute held it off.");
	end

	busy_on_compare: assert property (@(posedge clk_i) disable iff (rst_i)
		compare_item |-> !ready_o)
	else
	begin
		fails++;
		$error("Fetch was accepted while a branch compare item was out.");
	end

	jump_follows_compare: assert property (@(posedge clk_i) disable iff (rst_i)
		compare_item && ready_i && !jump_valid_i |=> valid_o && cmd_o.jump && !cmd_o.cmp)
	else
	begin
		fails++;
		$error("Branch compare item was not followed by its jump item.");
	end

	idle_after_reset: assert property (@(posedge clk_i)
		rst_i |=> !valid_o && ready_o && cmd_o == '0)
	else
	begin
		fails++;
		$error("Decoder is not idle after reset.");
	end

endmodule

/* tests/riscv_decode_tb.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module riscv_decode_tb;
	import decode_pkg::*;

	// Expected values on the output ports for one item.
	typedef struct packed
	{
		dec_cmd_t cmd;
		logic [3:0] jump_type;
		logic [`REG_AW-1:0] dst;
		logic [11:0] displacement;
		logic [3:0] trap_cause;
		logic [29:0] epc;
		logic [`XLEN-1:0] op1;
		logic [`XLEN-1:0] op2;
		logic [`XLEN-1:0] op3;
	} expected_t;

	logic clk_i;
	logic rst_i;
	logic [`XLEN-1:0] word_i;
	logic [29:0] next_ip_i;
	logic valid_i;
	logic ready_o;
	logic jump_valid_i;
	logic ready_i;
	logic valid_o;
	dec_cmd_t cmd_o;
	logic [3:0] jump_type_o;
	logic [`REG_AW-1:0] dst_o;
	logic [11:0] displacement_o;
	logic [3:0] trap_cause_o;
	logic [29:0] epc_o;
	logic [`XLEN-1:0] op1_o;
	logic [`XLEN-1:0] op2_o;
	logic [`XLEN-1:0] op3_o;
	logic [`REG_AW-1:0] sp_raddr1_o;
	logic [`REG_AW-1:0] sp_raddr2_o;
	logic [`XLEN-1:0] sp_rdata1_i;
	logic [`XLEN-1:0] sp_rdata2_i;

	logic [`XLEN-1:0] regs [32];
	expected_t exp_q [$];
	int errors = 0;
	int items = 0;
	int wait_cycles;

	riscv_decode i_riscv_decode
	(
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.word_i         (word_i),
		.next_ip_i      (next_ip_i),
		.valid_i        (valid_i),
		.ready_o        (ready_o),
		.jump_valid_i   (jump_valid_i),
		.ready_i        (ready_i),
		.valid_o        (valid_o),
		.cmd_o          (cmd_o),
		.jump_type_o    (jump_type_o),
		.dst_o          (dst_o),
		.displacement_o (displacement_o),
		.trap_cause_o   (trap_cause_o),
		.epc_o          (epc_o),
		.op1_o          (op1_o),
		.op2_o          (op2_o),
		.op3_o          (op3_o),
		.sp_raddr1_o    (sp_raddr1_o),
		.sp_rdata1_i    (sp_rdata1_i),
		.sp_raddr2_o    (sp_raddr2_o),
		.sp_rdata2_i    (sp_rdata2_i)
	);

	bind riscv_decode riscv_decode_props i_props
	(
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.ready_i        (ready_i),
		.jump_valid_i   (jump_valid_i),
		.valid_o        (valid_o),
		.ready_o        (ready_o),
		.cmd_o          (cmd_o),
		.jump_type_o    (jump_type_o),
		.dst_o          (dst_o),
		.displacement_o (displacement_o),
		.trap_cause_o   (trap_cause_o),
		.epc_o          (epc_o),
		.op1_o          (op1_o),
		.op2_o          (op2_o),
		.op3_o          (op3_o)
	);

	always #10 clk_i = ~clk_i;

	// Register file with synchronous reads, never written.
	always @(posedge clk_i)
	begin
		sp_rdata1_i <= regs[sp_raddr1_o[4:0]];
		sp_rdata2_i <= regs[sp_raddr2_o[4:0]];
		if (!rst_i)
		begin
			// Only 32 registers exist.
			check_value("sp_raddr1_o[7:5]", sp_raddr1_o[`REG_AW-1:5], 0);
			check_value("sp_raddr2_o[7:5]", sp_raddr2_o[`REG_AW-1:5], 0);
		end
	end

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want)
		begin
			errors++;
			$display("ERROR %s at %0t: got %h, expected %h", name, $time, got, want);
		end
	endtask

	function automatic logic [31:0] random_word();
		logic [31:0] w;
		logic [2:0] f3;
		w = $urandom();
		f3 = $urandom() % 6;
		case ($urandom() % 12)
			0: w[6:0] = {`OPC_IMM, 2'b11};
			1:
			begin
				w[6:0] = {`OPC_OP, 2'b11};
				w[31:25] = (f3 < 2) ? 7'h00 : ((f3 < 4) ? 7'h20 : 7'h01);
			end
			2:
			begin
				w[6:0] = {`OPC_LOAD, 2'b11};
				w[14:12] = $urandom() % 5;
				if (w[14:12] == 3'd3)
					w[14:12] = 3'd5;
			end
			3:
			begin
				w[6:0] = {`OPC_STORE, 2'b11};
				w[14:12] = $urandom() % 3;
			end
			4:
			begin
				w[6:0] = {`OPC_BRANCH, 2'b11};
				w[14:12] = (f3 < 2) ? f3 : f3 + 3'd2; // BEQ, BNE and BLT to BGEU.
			end
			5: w[6:0] = {`OPC_JAL, 2'b11};
			6:
			begin
				w[6:0] = {`OPC_JALR, 2'b11};
				w[14:12] = 3'd0;
			end
			7: w[6:0] = {(w[31] ? `OPC_LUI : `OPC_AUIPC), 2'b11};
			8: w = w[20] ? 32'h0010_0073 : 32'h0000_0073;
			9:
			begin
				w[6:0] = {`OPC_SYSTEM, 2'b11}; // CSR access.
				if (w[14:12] == 3'd0)
					w[14:12] = 3'd2;
			end
			10:
			begin
				w[6:0] = {`OPC_MISCMEM, 2'b11};
				w[14:13] = 2'b00; // FENCE or FENCE.I.
			end
			default:
			begin
				if (w[31])
					w[1:0] = {w[1], 1'b0};
				else
					w[6:0] = {(w[30] ? 5'b01110 : 5'b10100), 2'b11};
			end
		endcase
		return w;
	endfunction

	// Reference decode of one word into one or two expected items.
	task automatic expect_items
	(
		input logic [31:0] w,
		input logic [29:0] nip,
		output expected_t e,
		output expected_t j,
		output bit branch
	);
		logic [4:0] opc;
		logic [2:0] f3;
		logic [31:0] a_reg;
		logic [31:0] b_reg;
		logic [31:0] pc;
		logic [31:0] imm_i;
		logic bad;
		opc = w[6:2];
		f3 = w[14:12];
		a_reg = (w[19:15] == 5'd0) ? 32'd0 : regs[w[19:15]];
		b_reg = (w[24:20] == 5'd0) ? 32'd0 : regs[w[24:20]];
		pc = {nip - 30'd1, 2'b00};
		imm_i = {{20{w[31]}}, w[31:20]};
		bad = (w[1:0] != 2'b11);
		branch = 1'b0;
		e = '0;
		e.epc = nip - 30'd1;
		case (opc)
			`OPC_IMM, `OPC_OP:
			begin
				e.dst = w[11:7];
				e.op1 = a_reg;
				e.op2 = (opc == `OPC_OP) ? b_reg : imm_i;
				if (opc == `OPC_OP && w[31:25] == 7'h01)
					case (f3)
						3'd0: e.cmd = '{mul: 1, default: 0};
						3'd1: e.cmd = '{mul: 1, mul_high: 1, signed_op: 1, signed_b: 1, default: 0};
						3'd2: e.cmd = '{mul: 1, mul_high: 1, signed_op: 1, default: 0};
						3'd3: e.cmd = '{mul: 1, mul_high: 1, default: 0};
						3'd4: e.cmd = '{div: 1, signed_op: 1, default: 0};
						3'd5: e.cmd = '{div: 1, default: 0};
						3'd6: e.cmd = '{div: 1, div_mod: 1, signed_op: 1, default: 0};
						default: e.cmd = '{div: 1, div_mod: 1, default: 0};
					endcase
				else
					case (f3)
						3'd0: e.cmd = '{addsub: 1, negate_op2: (opc == `OPC_OP) && w[30], default: 0};
						3'd1: e.cmd = '{shift: 1, default: 0};
						3'd2, 3'd3:
						begin
							e.cmd = '{cmp: 1, negate_op2: 1, slt: 1, default: 0};
							e.jump_type = (f3 == 3'd2) ? 4'b0100 : 4'b0110; // SLT or SLTU.
						end
						3'd4: e.cmd = '{xor_op: 1, default: 0};
						3'd5: e.cmd = '{shift: 1, shift_right: 1, signed_op: w[30], default: 0};
						3'd6: e.cmd = '{and_op: 1, xor_op: 1, default: 0};
						default: e.cmd = '{and_op: 1, default: 0};
					endcase
			end
			`OPC_JAL, `OPC_JALR:
			begin
				e.cmd = '{jump: 1, loadop3: 1, default: 0};
				e.op3 = {nip, 2'b00};
				e.dst = w[11:7];
				if (opc == `OPC_JAL)
					e.op1 = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				else
				begin
					e.op1 = a_reg;
					e.displacement = w[31:20];
				end
			end
			`OPC_BRANCH:
			begin
				e.cmd = '{cmp: 1, negate_op2: 1, default: 0};
				e.jump_type = {1'b0, f3};
				e.op1 = a_reg;
				e.op2 = b_reg;
				branch = 1'b1;
			end
			`OPC_LOAD:
			begin
				e.cmd = '{dbus: 1, dbus_byte: f3[1:0] == 2'd0, dbus_hword: f3[1:0] == 2'd1,
					signed_op: !f3[2], default: 0};
				e.op1 = a_reg;
				e.displacement = w[31:20];
				e.dst = w[11:7];
			end
			`OPC_STORE:
			begin
				e.cmd = '{dbus: 1, dbus_store: 1, dbus_byte: f3[1:0] == 2'd0,
					dbus_hword: f3[1:0] == 2'd1, default: 0};
				e.op1 = a_reg;
				e.op2 = b_reg;
				e.displacement = {w[31:25], w[11:7]};
			end
			`OPC_LUI, `OPC_AUIPC:
			begin
				e.cmd = '{addsub: 1, default: 0};
				e.op1 = (opc == `OPC_LUI) ? 32'd0 : pc;
				e.op2 = {w[31:12], 12'h000};
				e.dst = w[11:7];
			end
			`OPC_SYSTEM:
				if (f3 != 3'd0 || w[31:21] != 11'd0)
					bad = 1'b1;
				else
				begin
					e.cmd = '{trap: 1, jump: 1, default: 0};
					e.trap_cause = w[20] ? `CAUSE_BREAK : `CAUSE_ECALL;
				end
			`OPC_MISCMEM: bad = bad | (f3 != 3'd0);
			default: bad = 1'b1;
		endcase
		if (bad)
		begin
			e = '0;
			e.epc = nip - 30'd1;
			e.cmd = '{trap: 1, jump: 1, default: 0};
			e.trap_cause = `CAUSE_ILLEGAL;
			branch = 1'b0;
		end
		// Jump half keeps the compare item apart from cmd and op1.
		j = e;
		j.cmd = '{jump: 1, default: 0};
		j.op1 = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
	endtask

	task automatic compare_output();
		expected_t e;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("Decoder presented an item at %0t with no instruction pending", $time);
		end
		else
		begin
			e = exp_q.pop_front();
			items++;
			check_value("cmd_o", cmd_o, e.cmd);
			check_value("jump_type_o", jump_type_o, e.jump_type);
			check_value("dst_o", dst_o, e.dst);
			check_value("displacement_o", displacement_o, e.displacement);
			check_value("trap_cause_o", trap_cause_o, e.trap_cause);
			check_value("epc_o", epc_o, e.epc);
			check_value("op1_o", op1_o, e.op1);
			check_value("op2_o", op2_o, e.op2);
			check_value("op3_o", op3_o, e.op3);
		end
	endtask

	task automatic record_accept();
		expected_t first;
		expected_t second;
		bit two;
		expect_items(word_i, next_ip_i, first, second, two);
		exp_q.push_back(first);
		if (two)
			exp_q.push_back(second);
	endtask

	always @(posedge clk_i)
	begin
		if (!rst_i)
		begin
			if (valid_o && ready_i)
				compare_output();
			if (jump_valid_i)
				exp_q.delete(); // Flush drops everything in flight.
			if (valid_i && ready_o)
				record_accept();
		end
	end

	initial
	begin
		void'($urandom(32'h40ff_08f0));
		for (int i = 0; i < 32; i++)
			regs[i] = $urandom();
		clk_i = 1'b0;
		rst_i = 1'b1;
		word_i = '0;
		next_ip_i = '0;
		valid_i = 1'b0;
		jump_valid_i = 1'b0;
		ready_i = 1'b0;
		sp_rdata1_i = '0;
		sp_rdata2_i = '0;
		repeat (16) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		check_value("valid_o", valid_o, 0);
		check_value("ready_o", ready_o, 1);
		check_value("cmd_o", cmd_o, 0);

		for (int cycle = 0; cycle < 4000; cycle++)
		begin
			@(posedge clk_i);
			#2;
			valid_i = ($urandom() % 5) != 0;
			word_i = random_word();
			next_ip_i = $urandom();
			ready_i = ($urandom() % 4) != 0;
			jump_valid_i = ($urandom() % 40) == 0;
			if (jump_valid_i)
				valid_i = 1'b0; // No fetch while execute redirects.
		end

		@(posedge clk_i);
		#2;
		valid_i = 1'b0;
		ready_i = 1'b1;
		jump_valid_i = 1'b0;
		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < 20)
		begin
			@(posedge clk_i);
			#1;
			wait_cycles++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("Timed out with %0d expected items never leaving the decoder", exp_q.size());
		end

		errors += i_riscv_decode.i_props.fails;
		$display("Items checked: %0d, errors: %0d", items, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
